//--- tb/tb_frontend_ref.svh
`ifndef TB_FRONTEND_REF_SVH
`define TB_FRONTEND_REF_SVH

// ----------------------------------------------------------------------------
// random source, galois lfsr shifted right
// ----------------------------------------------------------------------------
logic [31:0] lfsr_q = 32'h34ec_76ad;

function automatic logic rand_bit();
    lfsr_q = lfsr_q[0] ? (lfsr_q >> 1) ^ 32'h8020_0003 : lfsr_q >> 1;
    return lfsr_q[0];
endfunction

// ----------------------------------------------------------------------------
// program image
// ----------------------------------------------------------------------------

// b-type with rs1=x1, rs2=x2
function automatic logic [XLEN-1:0] enc_branch(input int off, input logic [2:0] f3);
    logic [12:0] o;
    o = off[12:0];
    return {o[12], o[10:5], 5'd2, 5'd1, f3, o[4:1], o[11], 7'b110_0011};
endfunction

// jal with rd=x0
function automatic logic [XLEN-1:0] enc_jal(input int off);
    logic [20:0] o;
    o = off[20:0];
    return {o[20], o[10:1], o[11], o[19:12], 5'd0, 7'b110_1111};
endfunction

function automatic logic [XLEN-1:0] prog_word(input logic [XLEN-1:0] addr);
    case (addr)
        32'h0000_1008: return enc_jal(24);
        // jalr x0, 0(x1)
        32'h0000_1024: return 32'h0000_8067;
        32'h0000_1028: return enc_branch(16, 3'b000);
        32'h0000_1030: return enc_branch(-8, 3'b001);
        32'h0000_1038: return enc_jal(-8);
        32'h0000_3008: return enc_branch(-8, 3'b100);
        // addi with fields folded from every address bit
        default: return {addr[11:0] ^ addr[23:12], addr[28:24], 3'b000,
                         2'b00, addr[31:29], 7'b001_0011};
    endcase
endfunction

// ----------------------------------------------------------------------------
// bht shadow, two-bit counters indexed by pc[5:2]
// ----------------------------------------------------------------------------
logic       shadow_valid [16];
logic [1:0] shadow_cnt   [16];

function automatic void bht_train(input logic [XLEN-1:0] pc, input logic taken);
    int idx;
    idx = pc[5:2];
    if (!shadow_valid[idx]) begin
        shadow_cnt[idx] = taken ? 2'd2 : 2'd1;
    end else if (taken && shadow_cnt[idx] < 2'd3) begin
        shadow_cnt[idx] = shadow_cnt[idx] + 2'd1;
    end else if (!taken && shadow_cnt[idx] > 2'd0) begin
        shadow_cnt[idx] = shadow_cnt[idx] - 2'd1;
    end
    shadow_valid[idx] = 1'b1;
endfunction

// expected kind, target and next fetch pc of one instruction
function automatic void ref_predict(input logic [XLEN-1:0] pc,
                                    input logic [XLEN-1:0] instr,
                                    output cf_e cf,
                                    output logic [XLEN-1:0] target,
                                    output logic [XLEN-1:0] next_pc);
    logic [XLEN-1:0] b_off;
    logic [XLEN-1:0] j_off;
    logic            taken;
    int              idx;
    b_off = XLEN'($signed({instr[31], instr[7], instr[30:25], instr[11:8], 1'b0}));
    j_off = XLEN'($signed({instr[31], instr[19:12], instr[20], instr[30:21], 1'b0}));
    idx = pc[5:2];
    cf = CF_NONE;
    target = '0;
    case (instr[6:0])
        OP_BRANCH: begin
            // unknown branch: backward taken
            taken = shadow_valid[idx] ? (shadow_cnt[idx] >= 2'd2) : b_off[XLEN-1];
            cf = taken ? CF_BRANCH_TAKEN : CF_BRANCH_NOT_TAKEN;
            target = pc + b_off;
        end
        OP_JAL: begin
            cf = CF_JUMP;
            target = pc + j_off;
        end
        OP_JALR: cf = CF_JUMPR;
        default: cf = CF_NONE;
    endcase
    next_pc = (cf == CF_JUMP || cf == CF_BRANCH_TAKEN) ? target : pc + 32'd4;
endfunction

// ----------------------------------------------------------------------------
// compare tasks
// ----------------------------------------------------------------------------
int err_cnt = 0;

task automatic check_pc(input string name, input logic [XLEN-1:0] got,
                        input logic [XLEN-1:0] exp);
    if (got !== exp) begin
        err_cnt++;
        $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
    end
endtask

task automatic check_instr(input string name, input logic [XLEN-1:0] got,
                           input logic [XLEN-1:0] exp);
    if (got !== exp) begin
        err_cnt++;
        $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
    end
endtask

task automatic check_cf(input string name, input cf_e got, input cf_e exp);
    if (got !== exp) begin
        err_cnt++;
        $display("[ERROR] %0t %s got %s expected %s", $time, name, got.name(), exp.name());
    end
endtask

`endif

//--- tb/tb_frontend.sv
`timescale 1ns/1ps

module tb_frontend;
    import fe_cfg_pkg::*;
    import fe_types_pkg::*;

    localparam int unsigned RESET_CYCLES = 10;
    // entries checked in each phase
    localparam int unsigned N_BOOT  = 16;
    localparam int unsigned N_TRAIN = 12;
    localparam int unsigned N_MISP  = 8;
    localparam int unsigned N_TRAP  = 10;
    localparam int unsigned N_TOTAL = N_BOOT + N_TRAIN + N_MISP + N_TRAP;
    localparam int unsigned CYCLE_LIMIT = 40 * N_TOTAL + RESET_CYCLES;

    logic            clk_i = 1'b0;
    logic            rst_ni;
    logic            imem_req_o, imem_gnt_i, imem_rvalid_i;
    logic [XLEN-1:0] imem_addr_o, imem_rdata_i;
    logic            resolve_valid_i, resolve_is_branch_i, resolve_taken_i;
    logic            resolve_mispredict_i, exception_i;
    logic [XLEN-1:0] resolve_pc_i, resolve_target_i, trap_vector_i;
    logic            fetch_valid_o, fetch_ready_i;
    logic [XLEN-1:0] fetch_pc_o, fetch_instr_o, fetch_target_o;
    cf_e             fetch_cf_o;

    `include "tb_frontend_ref.svh"

    // scoreboard state
    logic [XLEN-1:0] exp_pc = BOOT_ADDR;
    logic [XLEN-1:0] exp_target, exp_next;
    cf_e             exp_cf;
    int              seen_cnt = 0;
    int              cycle_cnt = 0;
    logic            hold_ready = 1'b0;
    // memory model state
    logic            mem_busy;
    logic [1:0]      mem_wait;
    logic [XLEN-1:0] mem_addr;

    always #2 clk_i = ~clk_i;

    frontend_top dut_i (.*);

    // ------------------------------------------------------------------------
    // memory and back-end ready, the only users of the lfsr
    // ------------------------------------------------------------------------
    always @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            imem_gnt_i    <= 1'b0;
            imem_rvalid_i <= 1'b0;
            fetch_ready_i <= 1'b0;
            mem_busy = 1'b0;
            mem_wait = 2'd0;
        end else begin
            fetch_ready_i <= hold_ready ? 1'b0 : rand_bit();
            imem_rvalid_i <= 1'b0;
            if (imem_req_o && imem_gnt_i) begin
                mem_addr = imem_addr_o;
                // latency 1..3
                mem_wait = {rand_bit(), rand_bit()};
                mem_wait = (mem_wait == 2'd0) ? 2'd3 : mem_wait;
                mem_busy = 1'b1;
                imem_gnt_i <= 1'b0;
            end else begin
                imem_gnt_i <= imem_req_o && !mem_busy && rand_bit();
                if (mem_busy) begin
                    mem_wait = mem_wait - 2'd1;
                    if (mem_wait == 2'd0) begin
                        imem_rvalid_i <= 1'b1;
                        imem_rdata_i  <= prog_word(mem_addr);
                        mem_busy = 1'b0;
                    end
                end
            end
        end
    end

    // scoreboard, walks the reference pc stream
    always @(posedge clk_i) begin
        if (rst_ni && fetch_valid_o && fetch_ready_i) begin
            ref_predict(exp_pc, prog_word(exp_pc), exp_cf, exp_target, exp_next);
            check_pc("fetch_pc_o", fetch_pc_o, exp_pc);
            check_instr("fetch_instr_o", fetch_instr_o, prog_word(exp_pc));
            check_cf("fetch_cf_o", fetch_cf_o, exp_cf);
            check_pc("fetch_target_o", fetch_target_o, exp_target);
            exp_pc = exp_next;
            seen_cnt++;
        end
    end

    always @(posedge clk_i) begin
        cycle_cnt++;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("timeout: %0d of %0d entries delivered, %0d errors",
                     seen_cnt, N_TOTAL, err_cnt);
            $display("TB FAILED");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------------
    task automatic wait_entries(input int n);
        while (seen_cnt < n) @(negedge clk_i);
    endtask

    // no transfer from here until the redirect is released
    task automatic stall_backend();
        hold_ready <= 1'b1;
        do @(posedge clk_i); while (fetch_ready_i);
    endtask

    task automatic train_branch(input logic [XLEN-1:0] pc, input logic taken);
        @(posedge clk_i);
        resolve_valid_i     <= 1'b1;
        resolve_is_branch_i <= 1'b1;
        resolve_pc_i        <= pc;
        resolve_taken_i     <= taken;
        @(posedge clk_i);
        resolve_valid_i     <= 1'b0;
        resolve_is_branch_i <= 1'b0;
        bht_train(pc, taken);
    endtask

    task automatic redirect_fetch(input logic misp, input logic exc,
                                  input logic [XLEN-1:0] target,
                                  input logic [XLEN-1:0] trap,
                                  input logic [XLEN-1:0] exp_start);
        @(posedge clk_i);
        resolve_valid_i      <= misp;
        resolve_mispredict_i <= misp;
        resolve_target_i     <= target;
        exception_i          <= exc;
        trap_vector_i        <= trap;
        exp_pc = exp_start;
        @(posedge clk_i);
        resolve_valid_i      <= 1'b0;
        resolve_mispredict_i <= 1'b0;
        exception_i          <= 1'b0;
        hold_ready <= 1'b0;
    endtask

    initial begin
        for (int i = 0; i < 16; i++) begin
            shadow_valid[i] = 1'b0;
            shadow_cnt[i]   = 2'd0;
        end
        rst_ni               = 1'b0;
        imem_gnt_i           = 1'b0;
        imem_rvalid_i        = 1'b0;
        imem_rdata_i         = '0;
        resolve_valid_i      = 1'b0;
        resolve_is_branch_i  = 1'b0;
        resolve_pc_i         = '0;
        resolve_taken_i      = 1'b0;
        resolve_mispredict_i = 1'b0;
        resolve_target_i     = '0;
        exception_i          = 1'b0;
        trap_vector_i        = '0;
        fetch_ready_i        = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_i);
        rst_ni <= 1'b1;

        // boot stream: jal, jalr, static branch prediction
        wait_entries(N_BOOT);

        // forward branch trained taken, backward trained not taken
        stall_backend();
        train_branch(32'h0000_1028, 1'b1);
        train_branch(32'h0000_1028, 1'b1);
        train_branch(32'h0000_1030, 1'b0);
        train_branch(32'h0000_1030, 1'b0);
        redirect_fetch(1'b1, 1'b0, 32'h0000_1028, '0, 32'h0000_1028);
        wait_entries(N_BOOT + N_TRAIN);

        // plain mispredict, likely with a request in flight
        stall_backend();
        redirect_fetch(1'b1, 1'b0, 32'h0000_2000, '0, 32'h0000_2000);
        wait_entries(N_BOOT + N_TRAIN + N_MISP);

        // trap vector beats the mispredict target
        stall_backend();
        redirect_fetch(1'b1, 1'b1, 32'h0000_2000, 32'h0000_3000, 32'h0000_3000);
        wait_entries(N_TOTAL);

        $display("checked %0d entries, %0d errors", seen_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- verilog/bht.sv
`timescale 1ns/1ps

module bht (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    // lookup for the instruction in the decode register
    input  logic [fe_cfg_pkg::XLEN-1:0] rd_pc_i,
    output logic                       valid_o,
    output logic                       taken_o,
    // training from resolved branches
    input  logic                       upd_valid_i,
    input  logic [fe_cfg_pkg::XLEN-1:0] upd_pc_i,
    input  logic                       upd_taken_i
);
    import fe_cfg_pkg::*;

    logic [BHT_ENTRIES-1:0] valid_q;
    logic [1:0]             cnt_q [BHT_ENTRIES];

    logic [BHT_IDX_W-1:0]   rd_idx;
    logic [BHT_IDX_W-1:0]   upd_idx;

    // word index, pc[1:0] is always zero without compressed code
    assign rd_idx  = rd_pc_i[BHT_IDX_W+1:2];
    assign upd_idx = upd_pc_i[BHT_IDX_W+1:2];

    assign valid_o = valid_q[rd_idx];
    // msb set means counter is 2 or 3
    assign taken_o = cnt_q[rd_idx][1];

    // ------------------------------------------------------------------------
    // entry valid bits
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
        end else if (upd_valid_i) begin
            valid_q[upd_idx] <= 1'b1;
        end
    end

    // ------------------------------------------------------------------------
    // saturating counters
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (upd_valid_i) begin
            if (!valid_q[upd_idx]) begin
                // first sighting, start weak in the resolved direction
                cnt_q[upd_idx] <= upd_taken_i ? 2'd2 : 2'd1;
            end else if (upd_taken_i && cnt_q[upd_idx] != 2'd3) begin
                cnt_q[upd_idx] <= cnt_q[upd_idx] + 2'd1;
            end else if (!upd_taken_i && cnt_q[upd_idx] != 2'd0) begin
                cnt_q[upd_idx] <= cnt_q[upd_idx] - 2'd1;
            end
        end
    end

endmodule

//--- verilog/branch_predict.sv
`timescale 1ns/1ps

module branch_predict (
    input  logic [fe_cfg_pkg::XLEN-1:0] dec_pc_i,
    input  logic [fe_cfg_pkg::XLEN-1:0] dec_instr_i,
    // dynamic prediction for dec_pc_i
    input  logic                       bht_valid_i,
    input  logic                       bht_taken_i,
    output fe_types_pkg::cf_e          cf_o,
    output logic [fe_cfg_pkg::XLEN-1:0] target_o,
    output logic [fe_cfg_pkg::XLEN-1:0] next_pc_o
);
    import fe_cfg_pkg::*;
    import fe_types_pkg::*;

    opcode_e         opcode;
    logic [XLEN-1:0] b_imm;
    logic [XLEN-1:0] j_imm;
    logic            br_taken;

    // ------------------------------------------------------------------------
    // pre-decode
    // ------------------------------------------------------------------------
    always_comb begin
        case (dec_instr_i[6:0])
            OP_BRANCH: opcode = OP_BRANCH;
            OP_JAL:    opcode = OP_JAL;
            OP_JALR:   opcode = OP_JALR;
            default:   opcode = OP_OTHER;
        endcase
    end

    // b-type offset, bit 0 always zero
    assign b_imm = {{19{dec_instr_i[31]}}, dec_instr_i[31], dec_instr_i[7],
                    dec_instr_i[30:25], dec_instr_i[11:8], 1'b0};
    // j-type offset for jal
    assign j_imm = {{11{dec_instr_i[31]}}, dec_instr_i[31], dec_instr_i[19:12],
                    dec_instr_i[20], dec_instr_i[30:21], 1'b0};

    // bht when it knows the branch, else backward taken / forward not taken
    assign br_taken = bht_valid_i ? bht_taken_i : b_imm[XLEN-1];

    // ------------------------------------------------------------------------
    // kind, target and next fetch address
    // ------------------------------------------------------------------------
    always_comb begin
        cf_o     = CF_NONE;
        target_o = '0;
        unique case (opcode)
            OP_BRANCH: begin
                cf_o     = br_taken ? CF_BRANCH_TAKEN : CF_BRANCH_NOT_TAKEN;
                target_o = dec_pc_i + b_imm;
            end
            OP_JAL: begin
                cf_o     = CF_JUMP;
                target_o = dec_pc_i + j_imm;
            end
            // no btb, so jalr just falls through
            OP_JALR:  cf_o = CF_JUMPR;
            default:  cf_o = CF_NONE;
        endcase
    end

    assign next_pc_o = (cf_o == CF_JUMP || cf_o == CF_BRANCH_TAKEN) ?
                       target_o : dec_pc_i + XLEN'(4);

endmodule

//--- verilog/fe_cfg_pkg.sv
package fe_cfg_pkg;

    // ------------------------------------------------------------------------
    // datapath widths
    // ------------------------------------------------------------------------

    // address and instruction width, rv32 only
    localparam int unsigned XLEN = 32;

    // first fetch address after reset
    localparam logic [XLEN-1:0] BOOT_ADDR = 32'h0000_1000;

    // ------------------------------------------------------------------------
    // branch history table
    // ------------------------------------------------------------------------

    // number of two-bit counters
    localparam int unsigned BHT_ENTRIES = 16;
    // pc bits above bit 1 that select a counter, pc[5:2]
    localparam int unsigned BHT_IDX_W = 4;

    // ------------------------------------------------------------------------
    // fetch queue
    // ------------------------------------------------------------------------

    // entries held toward the back end
    localparam int unsigned QUEUE_DEPTH = 4;
    // fill count width, must hold 0..QUEUE_DEPTH
    localparam int unsigned QUEUE_CNT_W = 3;

endpackage

//--- verilog/fe_types_pkg.sv
package fe_types_pkg;

    // ------------------------------------------------------------------------
    // major opcodes seen by the pre-decoder
    // ------------------------------------------------------------------------

    // values are the instr[6:0] encodings of the rv32i base set
    typedef enum logic [6:0] {
        // conditional branches beq..bgeu
        OP_BRANCH = 7'b110_0011,
        // pc relative jump with immediate
        OP_JAL    = 7'b110_1111,
        // register indirect jump
        OP_JALR   = 7'b110_0111,
        // anything that does not change control flow
        OP_OTHER  = 7'b000_0000
    } opcode_e;

    // ------------------------------------------------------------------------
    // control flow kind attached to every fetch entry
    // ------------------------------------------------------------------------

    typedef enum logic [2:0] {
        // plain instruction, next pc is pc+4
        CF_NONE             = 3'd0,
        // branch predicted taken, fetch continued at the target
        CF_BRANCH_TAKEN     = 3'd1,
        // branch predicted not taken, fetch continued at pc+4
        CF_BRANCH_NOT_TAKEN = 3'd2,
        // jal, target known at pre-decode
        CF_JUMP             = 3'd3,
        // jalr, target unknown here so fetch falls through
        CF_JUMPR            = 3'd4
    } cf_e;

endpackage

//--- verilog/fetch_queue.sv
`timescale 1ns/1ps

module fetch_queue (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  logic                       flush_i,
    // write side from the decode register
    input  logic                       push_i,
    input  logic [fe_cfg_pkg::XLEN-1:0] pc_i,
    input  logic [fe_cfg_pkg::XLEN-1:0] instr_i,
    input  fe_types_pkg::cf_e          cf_i,
    input  logic [fe_cfg_pkg::XLEN-1:0] target_i,
    output logic                       space_o,
    output logic                       full_o,
    // read side toward the back end
    output logic                       fetch_valid_o,
    input  logic                       fetch_ready_i,
    output logic [fe_cfg_pkg::XLEN-1:0] fetch_pc_o,
    output logic [fe_cfg_pkg::XLEN-1:0] fetch_instr_o,
    output fe_types_pkg::cf_e          fetch_cf_o,
    output logic [fe_cfg_pkg::XLEN-1:0] fetch_target_o
);
    import fe_cfg_pkg::*;
    import fe_types_pkg::*;

    logic [XLEN-1:0]        pc_mem     [QUEUE_DEPTH];
    logic [XLEN-1:0]        instr_mem  [QUEUE_DEPTH];
    cf_e                    cf_mem     [QUEUE_DEPTH];
    logic [XLEN-1:0]        target_mem [QUEUE_DEPTH];

    // depth is a power of two so pointers wrap on their own
    logic [QUEUE_CNT_W-2:0] wr_ptr_q;
    logic [QUEUE_CNT_W-2:0] rd_ptr_q;
    logic [QUEUE_CNT_W-1:0] cnt_q;
    logic                   pop;

    assign pop            = fetch_valid_o & fetch_ready_i;
    assign fetch_valid_o  = cnt_q != '0;
    assign full_o         = cnt_q == QUEUE_CNT_W'(QUEUE_DEPTH);
    // room for this entry plus the one behind it in the decode register
    assign space_o        = cnt_q <= QUEUE_CNT_W'(QUEUE_DEPTH - 2);

    assign fetch_pc_o     = pc_mem[rd_ptr_q];
    assign fetch_instr_o  = instr_mem[rd_ptr_q];
    assign fetch_cf_o     = cf_mem[rd_ptr_q];
    assign fetch_target_o = target_mem[rd_ptr_q];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            cnt_q    <= '0;
        end else if (flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            cnt_q    <= '0;
        end else begin
            if (push_i) wr_ptr_q <= wr_ptr_q + 1'b1;
            if (pop)    rd_ptr_q <= rd_ptr_q + 1'b1;
            case ({push_i, pop})
                2'b10:   cnt_q <= cnt_q + 1'b1;
                2'b01:   cnt_q <= cnt_q - 1'b1;
                default: cnt_q <= cnt_q;
            endcase
        end
    end

    // entry storage
    always_ff @(posedge clk_i) begin
        if (push_i) begin
            pc_mem[wr_ptr_q]     <= pc_i;
            instr_mem[wr_ptr_q]  <= instr_i;
            cf_mem[wr_ptr_q]     <= cf_i;
            target_mem[wr_ptr_q] <= target_i;
        end
    end

    no_push_full_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        push_i |-> !full_o);

    // valid/ready contract with the back end
    fetch_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        fetch_valid_o && !fetch_ready_i && !flush_i |=>
            fetch_valid_o && $stable(fetch_pc_o) && $stable(fetch_instr_o) &&
            $stable(fetch_cf_o) && $stable(fetch_target_o));

endmodule

//--- verilog/frontend_top.sv
`timescale 1ns/1ps

module frontend_top (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    // instruction memory
    output logic                       imem_req_o,
    output logic [fe_cfg_pkg::XLEN-1:0] imem_addr_o,
    input  logic                       imem_gnt_i,
    input  logic                       imem_rvalid_i,
    input  logic [fe_cfg_pkg::XLEN-1:0] imem_rdata_i,
    // branch resolution from the back end
    input  logic                       resolve_valid_i,
    input  logic                       resolve_is_branch_i,
    input  logic [fe_cfg_pkg::XLEN-1:0] resolve_pc_i,
    input  logic                       resolve_taken_i,
    input  logic                       resolve_mispredict_i,
    input  logic [fe_cfg_pkg::XLEN-1:0] resolve_target_i,
    input  logic                       exception_i,
    input  logic [fe_cfg_pkg::XLEN-1:0] trap_vector_i,
    // fetch entries to the back end
    output logic                       fetch_valid_o,
    input  logic                       fetch_ready_i,
    output logic [fe_cfg_pkg::XLEN-1:0] fetch_pc_o,
    output logic [fe_cfg_pkg::XLEN-1:0] fetch_instr_o,
    output fe_types_pkg::cf_e          fetch_cf_o,
    output logic [fe_cfg_pkg::XLEN-1:0] fetch_target_o
);
    import fe_cfg_pkg::*;
    import fe_types_pkg::*;

    logic            dec_valid_q, dec_push, capture;
    logic [XLEN-1:0] dec_pc_q, dec_instr_q;
    logic            redirect_valid;
    logic [XLEN-1:0] redirect_pc;
    logic            bht_valid, bht_taken, q_space, q_full;
    cf_e             cf;
    logic [XLEN-1:0] target, next_pc;
    logic            upd_valid_q, upd_taken_q;
    logic [XLEN-1:0] upd_pc_q;

    // trap beats mispredict
    assign redirect_valid = exception_i | (resolve_valid_i & resolve_mispredict_i);
    assign redirect_pc    = exception_i ? trap_vector_i : resolve_target_i;
    assign dec_push       = dec_valid_q & ~q_full;

    // ------------------------------------------------------------------------
    // decode register and registered bht training
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            dec_valid_q <= 1'b0;
            upd_valid_q <= 1'b0;
        end else begin
            upd_valid_q <= resolve_valid_i & resolve_is_branch_i;
            if (redirect_valid)   dec_valid_q <= 1'b0;
            else if (capture)     dec_valid_q <= 1'b1;
            else if (dec_push)    dec_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        // address is still held by pc_gen while the reply is out
        if (capture) begin
            dec_pc_q    <= imem_addr_o;
            dec_instr_q <= imem_rdata_i;
        end
        upd_pc_q    <= resolve_pc_i;
        upd_taken_q <= resolve_taken_i;
    end

    pc_gen i_pc_gen (
        .clk_i, .rst_ni, .imem_req_o, .imem_addr_o, .imem_gnt_i, .imem_rvalid_i,
        .next_pc_i        (next_pc),
        .advance_i        (dec_push),
        .space_i          (q_space),
        .redirect_valid_i (redirect_valid),
        .redirect_pc_i    (redirect_pc),
        .capture_o        (capture)
    );

    branch_predict i_branch_predict (
        .dec_pc_i (dec_pc_q), .dec_instr_i (dec_instr_q),
        .bht_valid_i (bht_valid), .bht_taken_i (bht_taken),
        .cf_o (cf), .target_o (target), .next_pc_o (next_pc)
    );

    bht i_bht (
        .clk_i, .rst_ni,
        .rd_pc_i (dec_pc_q), .valid_o (bht_valid), .taken_o (bht_taken),
        .upd_valid_i (upd_valid_q), .upd_pc_i (upd_pc_q), .upd_taken_i (upd_taken_q)
    );

    fetch_queue i_fetch_queue (
        .clk_i, .rst_ni,
        .flush_i (redirect_valid), .push_i (dec_push),
        .pc_i (dec_pc_q), .instr_i (dec_instr_q), .cf_i (cf), .target_i (target),
        .space_o (q_space), .full_o (q_full),
        .fetch_valid_o, .fetch_ready_i, .fetch_pc_o, .fetch_instr_o,
        .fetch_cf_o, .fetch_target_o
    );

endmodule

//--- verilog/pc_gen.sv
`timescale 1ns/1ps

module pc_gen (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    // instruction memory request side
    output logic                       imem_req_o,
    output logic [fe_cfg_pkg::XLEN-1:0] imem_addr_o,
    input  logic                       imem_gnt_i,
    input  logic                       imem_rvalid_i,
    // predicted pc from the decode register, valid with advance_i
    input  logic [fe_cfg_pkg::XLEN-1:0] next_pc_i,
    input  logic                       advance_i,
    input  logic                       space_i,
    // redirect from the back end, already prioritized
    input  logic                       redirect_valid_i,
    input  logic [fe_cfg_pkg::XLEN-1:0] redirect_pc_i,
    output logic                       capture_o
);
    import fe_cfg_pkg::*;

    logic            req_q;
    logic            out_q;
    logic            stale_q;
    logic            pend_q;
    logic [XLEN-1:0] addr_q;
    // address of the next fetch while it waits for room or for the bus
    logic [XLEN-1:0] npc_q;

    logic            rsp;
    logic            bus_free;
    logic            launch;
    logic [XLEN-1:0] launch_pc;

    assign imem_req_o  = req_q;
    assign imem_addr_o = addr_q;

    // the outstanding response comes back this cycle
    assign rsp       = out_q & imem_rvalid_i;
    // nothing requested and nothing in flight after this cycle
    assign bus_free  = ~req_q & (~out_q | imem_rvalid_i);
    // a redirect in the same cycle kills the response too
    assign capture_o = rsp & ~stale_q & ~redirect_valid_i;

    // a push hands over the next pc directly, otherwise use the parked one
    assign launch    = (pend_q | advance_i) & space_i & bus_free;
    assign launch_pc = advance_i ? next_pc_i : npc_q;

    // ------------------------------------------------------------------------
    // request state
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            req_q   <= 1'b0;
            out_q   <= 1'b0;
            stale_q <= 1'b0;
            // boot fetch is parked and leaves on the first clock
            pend_q  <= 1'b1;
            addr_q  <= BOOT_ADDR;
            npc_q   <= BOOT_ADDR;
        end else begin
            if (imem_req_o && imem_gnt_i) begin
                req_q <= 1'b0;
                out_q <= 1'b1;
            end
            if (rsp) begin
                out_q   <= 1'b0;
                stale_q <= 1'b0;
            end
            if (redirect_valid_i) begin
                if (bus_free) begin
                    req_q  <= 1'b1;
                    addr_q <= redirect_pc_i;
                    pend_q <= 1'b0;
                end else begin
                    // request stays up unchanged, its reply is dropped
                    stale_q <= 1'b1;
                    pend_q  <= 1'b1;
                    npc_q   <= redirect_pc_i;
                end
            end else if (launch) begin
                req_q  <= 1'b1;
                addr_q <= launch_pc;
                pend_q <= 1'b0;
            end else if (advance_i) begin
                // queue too full, wait for the back end to drain it
                pend_q <= 1'b1;
                npc_q  <= next_pc_i;
            end
        end
    end

    addr_aligned_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        imem_req_o |-> imem_addr_o[1:0] == 2'b00);

    // one transaction at a time on the memory port
    gnt_single_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        imem_gnt_i |-> !out_q);

endmodule

//--- vlog.f
+incdir+tb
verilog/fe_cfg_pkg.sv
verilog/fe_types_pkg.sv
verilog/bht.sv
verilog/branch_predict.sv
verilog/fetch_queue.sv
verilog/pc_gen.sv
verilog/frontend_top.sv
tb/tb_frontend.sv
